// File: noc_pkg.sv
package noc_pkg;

	// tree size
	localparam int unsigned N_LEAVES = 8;
	localparam int unsigned ADDR_W = 3;
	localparam int unsigned N_LEVELS = 3;

	// payload is four bits wider than the address
	localparam int unsigned PAYLOAD_W = ADDR_W + 4;

	// one link slot, all zero means empty
	typedef struct packed {
		logic valid;
		logic [ADDR_W-1:0] dest;
		logic [PAYLOAD_W-1:0] payload;
	} packet_t;

	// wanted direction of a packet, or source picked for an output port
	typedef enum logic [1:0] {
		DIR_VOID = 2'b00,
		DIR_LEFT = 2'b01,
		DIR_RIGHT = 2'b10,
		DIR_UP = 2'b11
	} dir_e;

	// where a packet wants to go from a switch at the given level and prefix
	function automatic dir_e route_dir(
		packet_t pkt,
		int unsigned level,
		int unsigned prefix
	);
		logic [ADDR_W-1:0] upper;
		logic [ADDR_W-1:0] pre;
		upper = pkt.dest >> (ADDR_W - level);
		pre = ADDR_W'(prefix);
		if (!pkt.valid) begin
			return DIR_VOID;
		end
		// level 0 shifts everything out, so the root never sends up
		if (upper != pre) begin
			return DIR_UP;
		end
		if (pkt.dest[ADDR_W-1-level]) begin
			return DIR_RIGHT;
		end
		return DIR_LEFT;
	endfunction

endpackage

// File: t_arbiter.sv
module t_arbiter #(
	parameter int unsigned LEVEL = 1
) (
	input noc_pkg::dir_e d_l_i,
	input noc_pkg::dir_e d_r_i,
	input noc_pkg::dir_e d_u_i,
	output noc_pkg::dir_e sel_l_o,
	output noc_pkg::dir_e sel_r_o,
	output noc_pkg::dir_e sel_u_o
);
	import noc_pkg::*;

	dir_e sel_l;
	dir_e sel_r;
	dir_e sel_u;

	assign sel_l_o = sel_l;
	assign sel_r_o = sel_r;
	assign sel_u_o = sel_u;

	generate
		if (LEVEL == 0) begin : g_root
			// root has no up port, packets either turn back or swap sides
			always_comb begin
				sel_l = DIR_VOID;
				sel_r = DIR_VOID;
				sel_u = DIR_VOID;
				if (d_l_i == DIR_LEFT)
					sel_l = DIR_LEFT;
				if (d_r_i == DIR_RIGHT)
					sel_r = DIR_RIGHT;
				if (sel_l == DIR_VOID && d_r_i == DIR_LEFT)
					sel_l = DIR_RIGHT;
				if (sel_l == DIR_LEFT && d_r_i == DIR_LEFT)
					sel_r = DIR_RIGHT;
				if (sel_r == DIR_VOID && d_l_i == DIR_RIGHT)
					sel_r = DIR_LEFT;
				if (sel_r == DIR_RIGHT && d_l_i == DIR_RIGHT)
					sel_l = DIR_LEFT;
			end
		end else begin : g_inner
			always_comb begin
				sel_l = DIR_VOID;
				sel_r = DIR_VOID;
				sel_u = DIR_VOID;

				// turnbacks keep the port they came in on
				if (d_l_i == DIR_LEFT)
					sel_l = DIR_LEFT;
				if (d_r_i == DIR_RIGHT)
					sel_r = DIR_RIGHT;

				// downlinks, bounced back up when a turnback holds the port
				if (d_u_i == DIR_UP) begin
					sel_u = DIR_UP;
				end else if (d_u_i == DIR_LEFT) begin
					if (d_l_i != DIR_LEFT)
						sel_l = DIR_UP;
					else
						sel_u = DIR_UP;
				end else if (d_u_i == DIR_RIGHT) begin
					if (d_r_i != DIR_RIGHT)
						sel_r = DIR_UP;
					else
						sel_u = DIR_UP;
				end

				// left packet, side link first then uplink
				if (d_l_i == DIR_RIGHT) begin
					if (sel_r == DIR_VOID)
						sel_r = DIR_LEFT;
					else if (d_u_i == DIR_LEFT)
						sel_u = DIR_LEFT;
					else
						sel_l = DIR_LEFT;
				end else if (d_l_i == DIR_UP) begin
					if (sel_u == DIR_VOID)
						sel_u = DIR_LEFT;
					else if (sel_l == DIR_VOID)
						sel_l = DIR_LEFT;
					else
						sel_r = DIR_LEFT;
				end

				// right packet takes whatever is left in its fall-back order
				if (d_r_i == DIR_LEFT) begin
					if (sel_l == DIR_VOID)
						sel_l = DIR_RIGHT;
					else if (sel_r == DIR_VOID)
						sel_r = DIR_RIGHT;
					else
						sel_u = DIR_RIGHT;
				end else if (d_r_i == DIR_UP) begin
					if (sel_u == DIR_VOID)
						sel_u = DIR_RIGHT;
					else if (sel_r == DIR_VOID)
						sel_r = DIR_RIGHT;
					else
						sel_l = DIR_RIGHT;
				end
			end
		end
	endgenerate

endmodule

// File: t_switch.sv
module t_switch #(
	parameter int unsigned LEVEL = 1,
	parameter int unsigned PREFIX = 0
) (
	input logic clk,
	input logic reset,
	input noc_pkg::packet_t l_i,
	input noc_pkg::packet_t r_i,
	input noc_pkg::packet_t u_i,
	output noc_pkg::packet_t l_o,
	output noc_pkg::packet_t r_o,
	output noc_pkg::packet_t u_o
);
	import noc_pkg::*;

	dir_e d_l;
	dir_e d_r;
	dir_e d_u;
	dir_e sel_l;
	dir_e sel_r;
	dir_e sel_u;

	// output mux, a void selection sends an empty slot
	function automatic packet_t pick(
		dir_e sel,
		packet_t from_l,
		packet_t from_r,
		packet_t from_u
	);
		case (sel)
			DIR_LEFT: return from_l;
			DIR_RIGHT: return from_r;
			DIR_UP: return from_u;
			default: return '0;
		endcase
	endfunction

	assign d_l = route_dir(l_i, LEVEL, PREFIX);
	assign d_r = route_dir(r_i, LEVEL, PREFIX);
	// root has no parent link
	assign d_u = (LEVEL == 0) ? DIR_VOID : route_dir(u_i, LEVEL, PREFIX);

	t_arbiter #(
		.LEVEL(LEVEL)
	) i_arbiter (
		.d_l_i(d_l),
		.d_r_i(d_r),
		.d_u_i(d_u),
		.sel_l_o(sel_l),
		.sel_r_o(sel_r),
		.sel_u_o(sel_u)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			l_o <= '0;
			r_o <= '0;
			u_o <= '0;
		end else begin
			l_o <= pick(sel_l, l_i, r_i, u_i);
			r_o <= pick(sel_r, l_i, r_i, u_i);
			u_o <= pick(sel_u, l_i, r_i, u_i);
		end
	end

endmodule

// File: leaf_port.sv
module leaf_port #(
	parameter int unsigned LEAF_ADDR = 0
) (
	input logic clk,
	input logic reset,
	input noc_pkg::packet_t bus_i,
	input noc_pkg::packet_t pe_pkt_i,
	output noc_pkg::packet_t bus_o,
	output noc_pkg::packet_t pe_pkt_o,
	output logic resend_o
);
	import noc_pkg::*;

	logic for_me;
	logic transit;

	assign for_me = bus_i.valid && (bus_i.dest == ADDR_W'(LEAF_ADDR));
	assign transit = bus_i.valid && (bus_i.dest != ADDR_W'(LEAF_ADDR));

	// a passing packet owns the uplink slot this cycle
	assign resend_o = transit;

	always_ff @(posedge clk) begin
		if (reset) begin
			pe_pkt_o <= '0;
			bus_o <= '0;
		end else begin
			if (for_me)
				pe_pkt_o <= bus_i;
			else
				pe_pkt_o <= '0;

			// deflected packet goes straight back up, PE must retry
			if (transit)
				bus_o <= bus_i;
			else
				bus_o <= pe_pkt_i;
		end
	end

endmodule

// File: tree_level.sv
module tree_level #(
	parameter int unsigned LEVEL = 0
) (
	input logic clk,
	input logic reset,
	input noc_pkg::packet_t down_i [2*(2**LEVEL)],
	output noc_pkg::packet_t down_o [2*(2**LEVEL)],
	input noc_pkg::packet_t up_i [2**LEVEL],
	output noc_pkg::packet_t up_o [2**LEVEL]
);

	localparam int unsigned N_SW = 2**LEVEL;

	// switch s owns child links 2s (left) and 2s+1 (right)
	generate
		for (genvar s = 0; s < N_SW; s++) begin : g_sw
			t_switch #(
				.LEVEL(LEVEL),
				.PREFIX(s)
			) i_switch (
				.clk(clk),
				.reset(reset),
				.l_i(down_i[2*s]),
				.r_i(down_i[2*s+1]),
				.u_i(up_i[s]),
				.l_o(down_o[2*s]),
				.r_o(down_o[2*s+1]),
				.u_o(up_o[s])
			);
		end
	endgenerate

endmodule

// File: tree_noc.sv
module tree_noc (
	input logic clk,
	input logic reset,
	input noc_pkg::packet_t pe_pkt_i [noc_pkg::N_LEAVES],
	output noc_pkg::packet_t pe_pkt_o [noc_pkg::N_LEAVES],
	output logic [noc_pkg::N_LEAVES-1:0] resend_o
);
	import noc_pkg::*;

	// links named by direction of travel
	packet_t leaf_to_l2 [N_LEAVES];
	packet_t l2_to_leaf [N_LEAVES];
	packet_t l2_to_l1 [N_LEAVES/2];
	packet_t l1_to_l2 [N_LEAVES/2];
	packet_t l1_to_l0 [N_LEAVES/4];
	packet_t l0_to_l1 [N_LEAVES/4];

	generate
		for (genvar k = 0; k < N_LEAVES; k++) begin : g_leaf
			leaf_port #(
				.LEAF_ADDR(k)
			) i_leaf (
				.clk(clk),
				.reset(reset),
				.bus_i(l2_to_leaf[k]),
				.pe_pkt_i(pe_pkt_i[k]),
				.bus_o(leaf_to_l2[k]),
				.pe_pkt_o(pe_pkt_o[k]),
				.resend_o(resend_o[k])
			);
		end
	endgenerate

	// bottom switch level, leaf k sits on switch k/2
	tree_level #(
		.LEVEL(N_LEVELS-1)
	) i_level2 (
		.clk(clk),
		.reset(reset),
		.down_i(leaf_to_l2),
		.down_o(l2_to_leaf),
		.up_i(l1_to_l2),
		.up_o(l2_to_l1)
	);

	tree_level #(
		.LEVEL(N_LEVELS-2)
	) i_level1 (
		.clk(clk),
		.reset(reset),
		.down_i(l2_to_l1),
		.down_o(l1_to_l2),
		.up_i(l0_to_l1),
		.up_o(l1_to_l0)
	);

	// root, nothing above it
	tree_level #(
		.LEVEL(0)
	) i_level0 (
		.clk(clk),
		.reset(reset),
		.down_i(l1_to_l0),
		.down_o(l0_to_l1),
		.up_i(),
		.up_o()
	);

endmodule

// File: tb_tree_noc.sv
module tb_tree_noc;
	timeunit 1ns;
	timeprecision 1ps;

	import noc_pkg::*;

	localparam int unsigned N_REC = 96;
	localparam int unsigned DRAIN = 20;

	logic clk;
	logic reset;
	packet_t pe_pkt_i [N_LEAVES];
	packet_t pe_pkt_o [N_LEAVES];
	logic [N_LEAVES-1:0] resend_o;

	// raw file image, four bytes per record
	logic [7:0] rec_mem [4*N_REC];

	int unsigned rec_src [N_REC];
	int unsigned rec_rel [N_REC];
	packet_t rec_pkt [N_REC];
	// 0 waiting, 1 in flight, 2 delivered
	int unsigned rec_state [N_REC];
	int unsigned rec_inj [N_REC];
	logic rec_alone [N_REC];

	int unsigned head [N_LEAVES];
	logic [N_LEAVES-1:0] taken;
	int unsigned cycle;
	int unsigned limit;
	int unsigned in_flight;
	int unsigned n_injected;
	int unsigned n_delivered;
	int unsigned value_errors;
	int unsigned other_errors;
	logic file_ok;
	logic seen_resend;

	tree_noc i_dut (
		.clk(clk),
		.reset(reset),
		.pe_pkt_i(pe_pkt_i),
		.pe_pkt_o(pe_pkt_o),
		.resend_o(resend_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			value_errors++;
			$display("** Error at %0d ns: %s expected %0h, got %0h",
				$time, name, expected, actual);
		end
	endtask

	// next record that leaf injects, N_REC when it has none left
	function automatic int unsigned next_rec(int unsigned leaf, int unsigned from);
		for (int unsigned r = from; r < N_REC; r++) begin
			if (rec_src[r] == leaf)
				return r;
		end
		return N_REC;
	endfunction

	// tree levels climbed on the way from src to dst
	function automatic int unsigned levels_up(int unsigned src, int unsigned dst);
		int unsigned h;
		h = 0;
		while ((src >> (h + 1)) != (dst >> (h + 1)))
			h++;
		return h;
	endfunction

	task automatic load_records();
		int unsigned rel;
		rel = 0;
		$readmemh("noc_input.txt", rec_mem);
		file_ok = !$isunknown(rec_mem[4*N_REC-1]);
		for (int unsigned i = 0; i < N_REC; i++) begin
			// gap counts from the release of the previous record
			rel += rec_mem[4*i+1];
			rec_src[i] = rec_mem[4*i];
			rec_rel[i] = rel;
			rec_pkt[i].valid = 1'b1;
			rec_pkt[i].dest = rec_mem[4*i+2][ADDR_W-1:0];
			rec_pkt[i].payload = rec_mem[4*i+3][PAYLOAD_W-1:0];
			rec_state[i] = 0;
			rec_inj[i] = 0;
			rec_alone[i] = 1'b0;
		end
		for (int unsigned k = 0; k < N_LEAVES; k++)
			head[k] = next_rec(k, 0);
		limit = rel + 64 * N_REC + 200;
	endtask

	task automatic record_injection(input int unsigned leaf);
		int unsigned r;
		r = head[leaf];
		// anything already in the tree now shares it
		if (in_flight > 0) begin
			for (int unsigned i = 0; i < N_REC; i++) begin
				if (rec_state[i] == 1)
					rec_alone[i] = 1'b0;
			end
		end
		rec_alone[r] = (in_flight == 0);
		rec_state[r] = 1;
		rec_inj[r] = cycle + 1;
		in_flight++;
		n_injected++;
	endtask

	task automatic accept_delivery(input int unsigned leaf, input packet_t p);
		int unsigned match;
		int unsigned want;
		string sig;
		match = N_REC;
		sig = $sformatf("pe_pkt_o[%0d].dest", leaf);
		check_value(sig, leaf, p.dest);
		for (int unsigned r = 0; r < N_REC; r++) begin
			if (rec_state[r] == 1 && rec_pkt[r].dest == leaf &&
					rec_pkt[r].payload == p.payload)
				match = r;
		end
		if (match == N_REC) begin
			other_errors++;
			$display("leaf %0d delivered payload %0h at %0d ns, but no such packet was in flight to it",
				leaf, p.payload, $time);
		end else begin
			rec_state[match] = 2;
			in_flight--;
			n_delivered++;
			// fixed latency only holds for a packet alone in the tree
			if (rec_alone[match]) begin
				want = 2 + 2 * levels_up(rec_src[match], leaf);
				sig = $sformatf("latency of payload %0h", p.payload);
				check_value(sig, want, cycle - rec_inj[match]);
			end
		end
	endtask

	task automatic watch_outputs();
		string sig;
		// deliveries first, a packet leaving now never sees the next injection
		for (int unsigned k = 0; k < N_LEAVES; k++) begin
			if (resend_o[k] === 1'b1)
				seen_resend = 1'b1;
			if (n_injected == 0) begin
				sig = $sformatf("pe_pkt_o[%0d]", k);
				check_value(sig, '0, pe_pkt_o[k]);
				sig = $sformatf("resend_o[%0d]", k);
				check_value(sig, 0, resend_o[k]);
			end
			if (pe_pkt_o[k].valid === 1'b1)
				accept_delivery(k, pe_pkt_o[k]);
		end
		// offer is taken at the coming edge unless a transit packet holds the slot
		for (int unsigned k = 0; k < N_LEAVES; k++) begin
			taken[k] = 1'b0;
			if (pe_pkt_i[k].valid && resend_o[k] !== 1'b1) begin
				taken[k] = 1'b1;
				record_injection(k);
			end
		end
	endtask

	task automatic drive_leaves();
		for (int unsigned k = 0; k < N_LEAVES; k++) begin
			if (taken[k])
				head[k] = next_rec(k, head[k] + 1);
			taken[k] = 1'b0;
			if (head[k] < N_REC && cycle >= rec_rel[head[k]])
				pe_pkt_i[k] <= rec_pkt[head[k]];
			else
				pe_pkt_i[k] <= '0;
		end
	endtask

	task automatic report_missing();
		for (int unsigned r = 0; r < N_REC; r++) begin
			if (rec_state[r] != 2) begin
				other_errors++;
				$display("packet with payload %0h from leaf %0d to leaf %0d %s",
					rec_pkt[r].payload, rec_src[r], rec_pkt[r].dest,
					(rec_state[r] == 0) ? "was never injected" : "never arrived");
			end
		end
	endtask

	always @(negedge clk) begin
		if (!reset)
			watch_outputs();
	end

	initial begin
		reset = 1'b1;
		taken = '0;
		cycle = 0;
		in_flight = 0;
		n_injected = 0;
		n_delivered = 0;
		value_errors = 0;
		other_errors = 0;
		seen_resend = 1'b0;
		for (int unsigned k = 0; k < N_LEAVES; k++)
			pe_pkt_i[k] = '0;
		load_records();

		repeat (5) @(posedge clk);
		reset <= 1'b0;

		if (file_ok) begin
			while (n_delivered < N_REC && cycle < limit) begin
				@(posedge clk);
				cycle++;
				drive_leaves();
			end
			if (n_delivered < N_REC) begin
				other_errors++;
				$display("timeout after %0d cycles with %0d of %0d packets delivered",
					cycle, n_delivered, N_REC);
			end
			// idle tail so a late duplicate still shows up
			repeat (DRAIN) begin
				@(posedge clk);
				cycle++;
				drive_leaves();
			end
			report_missing();
			if (!seen_resend) begin
				other_errors++;
				$display("resend_o never went high, no injection met a transit packet");
			end
		end else begin
			other_errors++;
			$display("could not read %0d records from noc_input.txt", N_REC);
		end

		$display("errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: noc_input.txt
// per record: source leaf, gap in cycles after the previous record, destination, payload
// four records per line; the first 64 go one at a time, the last 32 run concurrently
0 08 0 00  0 08 1 01  0 08 2 02  0 08 3 03
0 08 4 04  0 08 5 05  0 08 6 06  0 08 7 07
1 08 0 08  1 08 1 09  1 08 2 0a  1 08 3 0b
1 08 4 0c  1 08 5 0d  1 08 6 0e  1 08 7 0f
2 08 0 10  2 08 1 11  2 08 2 12  2 08 3 13
2 08 4 14  2 08 5 15  2 08 6 16  2 08 7 17
3 08 0 18  3 08 1 19  3 08 2 1a  3 08 3 1b
3 08 4 1c  3 08 5 1d  3 08 6 1e  3 08 7 1f
4 08 0 20  4 08 1 21  4 08 2 22  4 08 3 23
4 08 4 24  4 08 5 25  4 08 6 26  4 08 7 27
5 08 0 28  5 08 1 29  5 08 2 2a  5 08 3 2b
5 08 4 2c  5 08 5 2d  5 08 6 2e  5 08 7 2f
6 08 0 30  6 08 1 31  6 08 2 32  6 08 3 33
6 08 4 34  6 08 5 35  6 08 6 36  6 08 7 37
7 08 0 38  7 08 1 39  7 08 2 3a  7 08 3 3b
7 08 4 3c  7 08 5 3d  7 08 6 3e  7 08 7 3f
0 10 0 40  1 00 0 41  2 00 0 42  3 00 0 43
4 00 0 44  5 00 0 45  6 00 0 46  7 00 0 47
0 00 7 48  1 00 6 49  2 00 5 4a  3 00 4 4b
4 00 3 4c  5 00 2 4d  6 00 1 4e  7 00 0 4f
0 00 3 50  1 00 4 51  2 00 5 52  3 00 6 53
4 00 7 54  5 00 0 55  6 00 1 56  7 00 2 57
0 00 1 58  1 00 0 59  2 00 3 5a  3 00 2 5b
4 00 5 5c  5 00 4 5d  6 00 7 5e  7 00 6 5f

// File: list.f
noc_pkg.sv
t_arbiter.sv
t_switch.sv
leaf_port.sv
tree_level.sv
tree_noc.sv
tb_tree_noc.sv

// File: Bender.yml
package:
  name: tree_noc

sources:
  - noc_pkg.sv
  - t_arbiter.sv
  - t_switch.sv
  - leaf_port.sv
  - tree_level.sv
  - tree_noc.sv
  - target: test
    files:
      - tb_tree_noc.sv
